// ==== bus_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_master (
	input logic clk,
	input logic reset,
	input logic rx,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] setpoint,
	output logic tx,
	output logic tx_enable,
	output logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] position,
	output logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] velocity,
	output logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] displacement,
	output logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] duty,
	output bus_pkg::result_t [bus_pkg::NUM_MOTORS-1:0] error_code
);

	logic tx_req;
	logic tx_ack;
	logic [7:0] tx_byte;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic [bus_pkg::MOTOR_W-1:0] motor;
	logic timeout;
	logic command_sent;
	logic [bus_pkg::NUM_MOTORS-1:0] command_pending;

	status_bus_if status_bus ();

	uart_byte_tx tx0 (.clk(clk), .reset(reset), .req(tx_req), .data(tx_byte), .ack(tx_ack),
		.line(tx));

	uart_byte_rx rx0 (.clk(clk), .reset(reset), .line(rx), .valid(rx_valid), .data(rx_byte));

	status_receiver receiver0 (.clk(clk), .reset(reset), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.motor(motor), .timeout(timeout), .status(status_bus.source));

	poll_master master0 (.clk(clk), .reset(reset), .setpoint(setpoint),
		.command_pending(command_pending), .status(status_bus.sink), .tx_req(tx_req),
		.tx_byte(tx_byte), .tx_ack(tx_ack), .tx_enable(tx_enable), .motor(motor),
		.timeout(timeout), .command_sent(command_sent));

	for (genvar i = 0; i < bus_pkg::NUM_MOTORS; i++) begin : g_slot
		motor_slot #(.INDEX(i)) slot0 (.clk(clk), .reset(reset), .status(status_bus.sink),
			.setpoint(setpoint[i]), .command_sent(command_sent), .motor(motor),
			.command_pending(command_pending[i]), .position(position[i]),
			.velocity(velocity[i]), .displacement(displacement[i]), .duty(duty[i]),
			.error_code(error_code[i]));
	end

endmodule

`default_nettype wire

// ==== bus_patterns.txt ====
# name motor setpoint kind reported_setpoint position velocity displacement duty (values in hex)
# then expected result (0 ok, 1 no reply, 2 crc bad, 3 wrong id) and command expected (0 or 1)
m0_match 0 00000064 good 00000064 00001000 00000020 00000300 00004000 0 0
m1_lag 1 000001F4 good 00000190 FFFFF000 FFFFFFE0 00000010 00002000 0 1
m2_badcrc 2 00000000 badcrc 00000005 12345678 00000001 00000002 00000003 2 0
m3_silent 3 00000010 silent 00000000 00000000 00000000 00000000 00000000 1 0
m0_neg 0 FFFFFF9C good 00000064 00001100 FFFFFF00 00000310 00003000 0 1
m1_wrongid 1 000001F4 wrongid 000001F4 11111111 22222222 33333333 44444444 3 0
m2_good 2 00000000 good 00000000 0000ABCD 00000002 00000004 00000006 0 0
m3_good 3 00000010 good 00000020 7FFFFFFF 80000000 00000001 FFFFFFFF 0 1
m0_silent 0 FFFFFF9C silent 00000000 00000000 00000000 00000000 00000000 1 0
m1_after 1 000001F4 good 000001F4 00000500 00000005 00000050 00000500 0 0

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	localparam int NUM_MOTORS = 4;
	localparam int MOTOR_W = $clog2(NUM_MOTORS);
	localparam logic [7:0] MOTOR_ID_BASE = 8'h10;

	localparam int CLKS_PER_BIT = 8; // small for simulation
	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CLK_CNT_W-1:0] BIT_END = CLK_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CLK_CNT_W-1:0] HALF_BIT = CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);

	localparam logic [31:0] REQUEST_HEADER = 32'h1CE1CEBB;
	localparam logic [31:0] RESPONSE_HEADER = 32'hDABAD000;
	localparam logic [31:0] COMMAND_HEADER = 32'hCAFEBABE;

	localparam int HEADER_LEN = 4;
	localparam int REQUEST_LEN = 7;
	localparam int RESPONSE_LEN = 28;
	localparam int COMMAND_LEN = 11;

	// whole response plus two bytes of slack, ten bits per byte
	localparam int RESPONSE_TIMEOUT = (RESPONSE_LEN + 2) * 10 * CLKS_PER_BIT;
	localparam int TIMEOUT_W = $clog2(RESPONSE_TIMEOUT);
	localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(RESPONSE_TIMEOUT - 1);

	// poll_master states
	localparam logic [1:0] PM_SEND = 2'd0;
	localparam logic [1:0] PM_WAIT = 2'd1;
	localparam logic [1:0] PM_DECIDE = 2'd2;
	localparam logic [1:0] PM_NEXT = 2'd3;

	// status_receiver states
	localparam logic [1:0] RX_HUNT = 2'd0;
	localparam logic [1:0] RX_CAPTURE = 2'd1;
	localparam logic [1:0] RX_CHECK = 2'd2;
	localparam logic [1:0] RX_EMIT = 2'd3;

	typedef enum logic [1:0] {
		RES_OK       = 2'd0,
		RES_NO_REPLY = 2'd1,
		RES_CRC_BAD  = 2'd2,
		RES_WRONG_ID = 2'd3
	} result_t;

	// ccitt poly, msb first
	function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc ^ {data, 8'h00};
		for (int i = 0; i < 8; i++) begin
			c = c[15] ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== list.f ====
bus_pkg.sv
status_bus_if.sv
uart_byte_tx.sv
uart_byte_rx.sv
status_receiver.sv
motor_slot.sv
poll_master.sv
bus_master.sv
tb_checker.sv
tb_bus_master.sv

// ==== motor_slot.sv ====
`timescale 1ns/1ns
`default_nettype none

module motor_slot #(
	parameter int INDEX = 0
) (
	input logic clk,
	input logic reset,
	status_bus_if.sink status,
	input logic signed [31:0] setpoint,
	input logic command_sent,
	input logic [bus_pkg::MOTOR_W-1:0] motor,
	output logic command_pending,
	output logic signed [31:0] position,
	output logic signed [31:0] velocity,
	output logic signed [31:0] displacement,
	output logic signed [31:0] duty,
	output bus_pkg::result_t error_code
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			command_pending <= 1'b0;
			position <= '0;
			velocity <= '0;
			displacement <= '0;
			duty <= '0;
			error_code <= bus_pkg::RES_NO_REPLY;
		end else if (status.valid && status.motor == bus_pkg::MOTOR_W'(INDEX)) begin
			error_code <= status.result;
			command_pending <= 1'b0;
			if (status.result == bus_pkg::RES_OK) begin
				position <= status.position;
				velocity <= status.velocity;
				displacement <= status.displacement;
				duty <= status.duty;
				command_pending <= (status.setpoint != setpoint); // motor lags the applied value
			end
		end else if (command_sent && motor == bus_pkg::MOTOR_W'(INDEX)) begin
			command_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== poll_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module poll_master (
	input logic clk,
	input logic reset,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] setpoint,
	input logic [bus_pkg::NUM_MOTORS-1:0] command_pending,
	status_bus_if.sink status,
	output logic tx_req,
	output logic [7:0] tx_byte,
	input logic tx_ack,
	output logic tx_enable,
	output logic [bus_pkg::MOTOR_W-1:0] motor,
	output logic timeout,
	output logic command_sent
);

	logic [1:0] state;
	logic is_cmd; // command frame instead of request
	logic [3:0] byte_idx;
	logic [3:0] frame_len;
	logic [15:0] crc;
	logic [31:0] header;
	logic [31:0] cmd_word;
	logic [bus_pkg::TIMEOUT_W-1:0] wait_cnt;
	logic timed_out;

	assign header = is_cmd ? bus_pkg::COMMAND_HEADER : bus_pkg::REQUEST_HEADER;
	assign frame_len = is_cmd ? 4'(bus_pkg::COMMAND_LEN) : 4'(bus_pkg::REQUEST_LEN);
	assign cmd_word = setpoint[motor];

	always_comb begin
		if (byte_idx < bus_pkg::HEADER_LEN)
			tx_byte = header[8*(bus_pkg::HEADER_LEN-1-byte_idx) +: 8];
		else if (byte_idx == bus_pkg::HEADER_LEN)
			tx_byte = bus_pkg::MOTOR_ID_BASE + motor;
		else if (byte_idx == frame_len - 4'd2)
			tx_byte = crc[15:8];
		else if (byte_idx == frame_len - 4'd1)
			tx_byte = crc[7:0];
		else
			tx_byte = cmd_word[8*(bus_pkg::HEADER_LEN+4-byte_idx) +: 8]; // setpoint, msb first
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= bus_pkg::PM_SEND;
			motor <= '0;
			is_cmd <= 1'b0;
			byte_idx <= '0;
			crc <= 16'hFFFF;
			tx_req <= 1'b0;
			tx_enable <= 1'b0;
			timeout <= 1'b0;
			command_sent <= 1'b0;
			wait_cnt <= '0;
			timed_out <= 1'b0;
		end else begin
			timeout <= 1'b0;
			command_sent <= 1'b0;
			case (state)
				bus_pkg::PM_SEND: begin
					if (!tx_req && !tx_ack) begin
						tx_req <= 1'b1;
						tx_enable <= 1'b1;
					end else if (tx_req && tx_ack) begin
						tx_req <= 1'b0;
						if (byte_idx >= bus_pkg::HEADER_LEN && byte_idx < frame_len - 4'd2)
							crc <= bus_pkg::crc16_next(crc, tx_byte);
						if (byte_idx == frame_len - 4'd1) begin
							tx_enable <= 1'b0;
							if (is_cmd) begin
								command_sent <= 1'b1;
								state <= bus_pkg::PM_NEXT;
							end else begin
								wait_cnt <= bus_pkg::TIMEOUT_LAST;
								timed_out <= 1'b0;
								state <= bus_pkg::PM_WAIT;
							end
						end else begin
							byte_idx <= byte_idx + 4'd1;
						end
					end
				end
				bus_pkg::PM_WAIT: begin
					if (status.valid) begin
						state <= bus_pkg::PM_DECIDE;
					end else if (!timed_out) begin
						if (wait_cnt == '0) begin
							timeout <= 1'b1; // receiver answers with no reply
							timed_out <= 1'b1;
						end else begin
							wait_cnt <= wait_cnt - 1'b1;
						end
					end
				end
				bus_pkg::PM_DECIDE: begin
					// slot has settled its pending bit by now
					byte_idx <= '0;
					crc <= 16'hFFFF;
					if (command_pending[motor]) begin
						is_cmd <= 1'b1;
						state <= bus_pkg::PM_SEND;
					end else begin
						state <= bus_pkg::PM_NEXT;
					end
				end
				default: begin
					motor <= (motor == bus_pkg::NUM_MOTORS - 1) ? '0 : motor + 1'b1;
					is_cmd <= 1'b0;
					byte_idx <= '0;
					crc <= 16'hFFFF;
					state <= bus_pkg::PM_SEND;
				end
			endcase
		end
	end

	a_cmd_only_pending: assert property (@(posedge clk) disable iff (reset)
		command_sent |-> command_pending[motor]);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_master -f list.f \
	-o sim_bus_master > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_bus_master > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== status_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface status_bus_if;
	logic valid; // one cycle per poll
	logic [bus_pkg::MOTOR_W-1:0] motor;
	bus_pkg::result_t result;
	logic signed [31:0] setpoint;
	logic signed [31:0] position;
	logic signed [31:0] velocity;
	logic signed [31:0] displacement;
	logic signed [31:0] duty;

	modport source(output valid, motor, result, setpoint, position, velocity, displacement, duty);
	modport sink(input valid, motor, result, setpoint, position, velocity, displacement, duty);
endinterface

`default_nettype wire

// ==== status_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

module status_receiver (
	input logic clk,
	input logic reset,
	input logic rx_valid,
	input logic [7:0] rx_byte,
	input logic [bus_pkg::MOTOR_W-1:0] motor,
	input logic timeout,
	status_bus_if.source status
);

	logic [1:0] state;
	logic [4:0] byte_cnt;
	logic [23:0] window; // last three bytes, newest at the bottom
	logic [15:0] crc;
	logic [8*(bus_pkg::RESPONSE_LEN-bus_pkg::HEADER_LEN)-1:0] frame;
	logic crc_ok;
	logic id_ok;

	// frame holds id, mode, setpoint, pos, vel, disp, duty, crc from the top down
	assign status.setpoint = frame[175:144];
	assign status.position = frame[143:112];
	assign status.velocity = frame[111:80];
	assign status.displacement = frame[79:48];
	assign status.duty = frame[47:16];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= bus_pkg::RX_HUNT;
			byte_cnt <= '0;
			window <= '0;
			crc <= 16'hFFFF;
			crc_ok <= 1'b0;
			id_ok <= 1'b0;
			status.valid <= 1'b0;
			status.motor <= '0;
			status.result <= bus_pkg::RES_NO_REPLY;
		end else begin
			status.valid <= 1'b0;
			if (timeout && (state == bus_pkg::RX_HUNT || state == bus_pkg::RX_CAPTURE)) begin
				status.valid <= 1'b1;
				status.motor <= motor;
				status.result <= bus_pkg::RES_NO_REPLY;
				state <= bus_pkg::RX_HUNT;
			end else begin
				case (state)
					bus_pkg::RX_HUNT: if (rx_valid) begin
						window <= {window[15:0], rx_byte};
						if ({window, rx_byte} == bus_pkg::RESPONSE_HEADER) begin
							window <= '0;
							byte_cnt <= 5'(bus_pkg::HEADER_LEN);
							crc <= 16'hFFFF;
							state <= bus_pkg::RX_CAPTURE;
						end
					end
					bus_pkg::RX_CAPTURE: if (rx_valid) begin
						byte_cnt <= byte_cnt + 5'd1;
						if (byte_cnt < bus_pkg::RESPONSE_LEN - 2)
							crc <= bus_pkg::crc16_next(crc, rx_byte);
						if (byte_cnt == bus_pkg::RESPONSE_LEN - 1)
							state <= bus_pkg::RX_CHECK;
					end
					bus_pkg::RX_CHECK: begin
						crc_ok <= (crc == frame[15:0]);
						id_ok <= (frame[191:184] == bus_pkg::MOTOR_ID_BASE + motor);
						state <= bus_pkg::RX_EMIT;
					end
					default: begin
						status.valid <= 1'b1;
						status.motor <= motor;
						if (!crc_ok)
							status.result <= bus_pkg::RES_CRC_BAD;
						else if (!id_ok)
							status.result <= bus_pkg::RES_WRONG_ID;
						else
							status.result <= bus_pkg::RES_OK;
						state <= bus_pkg::RX_HUNT;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == bus_pkg::RX_CAPTURE && rx_valid && !timeout)
			frame <= {frame[$bits(frame)-9:0], rx_byte};
	end

	a_single_valid: assert property (@(posedge clk) disable iff (reset)
		status.valid |=> !status.valid);

endmodule

`default_nettype wire

// ==== tb_bus_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_bus_master;

	localparam int BIT_CLKS = bus_pkg::CLKS_PER_BIT;
	// longest poll: request, full wait, command, some slack
	localparam int POLL_CLKS = bus_pkg::RESPONSE_TIMEOUT
		+ (bus_pkg::REQUEST_LEN + bus_pkg::COMMAND_LEN) * 10 * BIT_CLKS + 200;

	logic clk;
	logic reset;
	logic rx;
	logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] setpoint;
	logic tx;
	logic tx_enable;
	logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] position;
	logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] velocity;
	logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] displacement;
	logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] duty;
	bus_pkg::result_t [bus_pkg::NUM_MOTORS-1:0] error_code;

	logic respond;
	logic [bus_pkg::MOTOR_W-1:0] resp_motor;
	logic signed [31:0] resp_setpoint;
	logic resp_silent;
	logic [8*bus_pkg::RESPONSE_LEN-1:0] resp_frame;
	int num_tests;
	logic done;
	int error_total;
	int cycles;
	int limit;

	bus_master dut0 (.clk(clk), .reset(reset), .rx(rx), .setpoint(setpoint), .tx(tx),
		.tx_enable(tx_enable), .position(position), .velocity(velocity),
		.displacement(displacement), .duty(duty), .error_code(error_code));

	tb_checker check0 (.clk(clk), .reset(reset), .tx(tx), .tx_enable(tx_enable),
		.position(position), .velocity(velocity), .displacement(displacement), .duty(duty),
		.error_code(error_code), .respond(respond), .resp_motor(resp_motor),
		.resp_setpoint(resp_setpoint), .resp_silent(resp_silent), .resp_frame(resp_frame),
		.num_tests(num_tests), .done(done), .error_total(error_total));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic send_byte(input logic [7:0] b);
		rx <= 1'b0; // start bit
		repeat (BIT_CLKS) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			rx <= b[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
		rx <= 1'b1;
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	// motor model, answers the request the checker has just decoded
	initial begin
		rx = 1'b1;
		setpoint = '0;
		forever begin
			@(posedge clk);
			if (respond) begin
				setpoint[resp_motor] <= resp_setpoint;
				if (!resp_silent)
					for (int k = bus_pkg::RESPONSE_LEN - 1; k >= 0; k--)
						send_byte(resp_frame[8*k +: 8]);
			end
		end
	end

	initial begin
		reset = 1'b1;
		cycles = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		limit = (num_tests + 1) * POLL_CLKS + 1000;
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (done && error_total == 0) begin
			$display("TEST PASSED");
		end else begin
			if (!done)
				$display("timeout: tests did not finish within %0d cycles", limit);
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
	input logic clk,
	input logic reset,
	input logic tx,
	input logic tx_enable,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] position,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] velocity,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] displacement,
	input logic signed [bus_pkg::NUM_MOTORS-1:0][31:0] duty,
	input bus_pkg::result_t [bus_pkg::NUM_MOTORS-1:0] error_code,
	output logic respond,
	output logic [bus_pkg::MOTOR_W-1:0] resp_motor,
	output logic signed [31:0] resp_setpoint,
	output logic resp_silent,
	output logic [8*bus_pkg::RESPONSE_LEN-1:0] resp_frame,
	output int num_tests,
	output logic done,
	output int error_total
);

	localparam int MAX_TESTS = 32;

	string names[MAX_TESTS];
	string kinds[MAX_TESTS];
	int motors[MAX_TESTS];
	logic [31:0] setpoints[MAX_TESTS];
	logic [31:0] reported[MAX_TESTS];
	logic [31:0] meas[MAX_TESTS][4]; // position, velocity, displacement, duty
	int exp_result[MAX_TESTS];
	int exp_cmd[MAX_TESTS];
	logic [31:0] last_meas[bus_pkg::NUM_MOTORS][4]; // what each motor's outputs should hold
	logic [7:0] frame_q[$];
	int cur;
	int test_errs;
	int line_errs;
	int passed;
	int failed;
	logic cmd_seen;

	// ccitt, one data bit at a time, msb first
	function automatic logic [15:0] crc_add(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ b[i];
			c = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
		end
		return c;
	endfunction

	function automatic logic [31:0] word_at(input int k);
		return {frame_q[k], frame_q[k+1], frame_q[k+2], frame_q[k+3]};
	endfunction

	function automatic logic [15:0] frame_crc();
		logic [15:0] crc;
		crc = 16'hFFFF;
		for (int k = bus_pkg::HEADER_LEN; k < frame_q.size() - 2; k++)
			crc = crc_add(crc, frame_q[k]);
		return crc;
	endfunction

	function automatic logic [31:0] dut_meas(input int m, input int k);
		case (k)
			0: return position[m];
			1: return velocity[m];
			2: return displacement[m];
			default: return duty[m];
		endcase
	endfunction

	function automatic string meas_name(input int k);
		case (k)
			0: return "position";
			1: return "velocity";
			2: return "displacement";
			default: return "duty";
		endcase
	endfunction

	function automatic logic [8*bus_pkg::RESPONSE_LEN-1:0] build_response(input int t);
		logic [175:0] body;
		logic [15:0] crc;
		body = {bus_pkg::MOTOR_ID_BASE + 8'(motors[t]), 8'h01, reported[t],
			meas[t][0], meas[t][1], meas[t][2], meas[t][3]};
		if (kinds[t] == "wrongid")
			body[175:168] = body[175:168] + 8'd1;
		crc = 16'hFFFF;
		for (int k = 21; k >= 0; k--)
			crc = crc_add(crc, body[8*k +: 8]);
		if (kinds[t] == "badcrc")
			crc = ~crc;
		return {bus_pkg::RESPONSE_HEADER, body, crc};
	endfunction

	task automatic check_value(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", test, what, exp, act);
			test_errs++;
			error_total++;
		end
	endtask

	task automatic report_problem(input string test, input string msg);
		$display("%s: %s", test, msg);
		test_errs++;
		error_total++;
	endtask

	task automatic check_frame(input string test, input logic [31:0] header, input int m);
		int len;
		len = frame_q.size();
		check_value(test, "header", header, word_at(0));
		check_value(test, "id", 32'(bus_pkg::MOTOR_ID_BASE + 8'(m)), 32'(frame_q[4]));
		check_value(test, "crc", 32'(frame_crc()), 32'({frame_q[len-2], frame_q[len-1]}));
	endtask

	task automatic finish_test(input int t);
		int m;
		m = motors[t];
		if (exp_cmd[t] != 0 && !cmd_seen)
			report_problem(names[t], "command frame expected but none was sent");
		if (exp_result[t] == 0)
			for (int k = 0; k < 4; k++)
				last_meas[m][k] = meas[t][k];
		check_value(names[t], "error_code", 32'(exp_result[t]), 32'(error_code[m]));
		for (int k = 0; k < 4; k++)
			check_value(names[t], meas_name(k), last_meas[m][k], dut_meas(m, k));
		if (test_errs == 0) begin
			$display("test %s passed", names[t]);
			passed++;
		end else begin
			$display("test %s failed with %0d errors", names[t], test_errs);
			failed++;
		end
	endtask

	task automatic take_request();
		if (cur >= 0)
			finish_test(cur);
		cur++;
		test_errs = 0;
		cmd_seen = 1'b0;
		if (cur < num_tests) begin
			check_frame(names[cur], bus_pkg::REQUEST_HEADER, motors[cur]);
			resp_motor = bus_pkg::MOTOR_W'(motors[cur]);
			resp_setpoint = setpoints[cur];
			resp_silent = (kinds[cur] == "silent");
			resp_frame = build_response(cur);
			respond = 1'b1;
		end else begin
			// polling wraps on past the last test
			check_frame("closing poll", bus_pkg::REQUEST_HEADER,
				(motors[num_tests-1] + 1) % bus_pkg::NUM_MOTORS);
			error_total += line_errs;
			$display("%0d tests, %0d passed, %0d failed, %0d errors", num_tests, passed, failed,
				error_total);
			done = 1'b1;
		end
	endtask

	task automatic take_command();
		if (cur < 0 || cur >= num_tests) begin
			report_problem("tx", "command frame sent outside any test");
		end else if (exp_cmd[cur] == 0 || cmd_seen) begin
			report_problem(names[cur], "command frame sent where none was due");
		end else begin
			cmd_seen = 1'b1;
			check_frame(names[cur], bus_pkg::COMMAND_HEADER, motors[cur]);
			check_value(names[cur], "command setpoint", setpoints[cur], word_at(5));
		end
	endtask

	// tx byte decoder, sampled mid-bit on the falling edge
	initial begin
		logic [7:0] b;
		line_errs = 0;
		forever begin
			@(negedge clk);
			if (!reset && tx === 1'b0) begin
				repeat (bus_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (bus_pkg::CLKS_PER_BIT) @(negedge clk);
					b[i] = tx;
				end
				repeat (bus_pkg::CLKS_PER_BIT) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("tx stop bit was low for byte %h", b);
					line_errs++;
				end
				frame_q.push_back(b);
			end
		end
	end

	initial begin
		int fd;
		int n;
		string line;
		string name;
		string kind;
		int motor;
		int res;
		int cmd;
		logic [31:0] sp;
		logic [31:0] rsp;
		logic [31:0] p;
		logic [31:0] v;
		logic [31:0] d;
		logic [31:0] u;
		logic en_prev;
		num_tests = 0;
		error_total = 0;
		done = 1'b0;
		respond = 1'b0;
		resp_motor = '0;
		resp_setpoint = '0;
		resp_silent = 1'b0;
		resp_frame = '0;
		cur = -1;
		test_errs = 0;
		passed = 0;
		failed = 0;
		cmd_seen = 1'b0;
		for (int m = 0; m < bus_pkg::NUM_MOTORS; m++)
			for (int k = 0; k < 4; k++)
				last_meas[m][k] = '0;
		fd = $fopen("bus_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open bus_patterns.txt");
			error_total = 1;
			done = 1'b1;
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %d %h %s %h %h %h %h %h %d %d", name, motor, sp, kind,
						rsp, p, v, d, u, res, cmd);
					if (n == 11) begin
						names[num_tests] = name;
						motors[num_tests] = motor;
						setpoints[num_tests] = sp;
						kinds[num_tests] = kind;
						reported[num_tests] = rsp;
						meas[num_tests][0] = p;
						meas[num_tests][1] = v;
						meas[num_tests][2] = d;
						meas[num_tests][3] = u;
						exp_result[num_tests] = res;
						exp_cmd[num_tests] = cmd;
						num_tests++;
					end
				end
			end
			$fclose(fd);
			if (num_tests == 0) begin
				$display("no tests found in bus_patterns.txt");
				error_total = 1;
				done = 1'b1;
			end
		end
		en_prev = 1'b0;
		forever begin
			@(negedge clk);
			respond = 1'b0;
			if (en_prev && !tx_enable && !done) begin // frame ends when tx_enable drops
				if (frame_q.size() == bus_pkg::REQUEST_LEN)
					take_request();
				else if (frame_q.size() == bus_pkg::COMMAND_LEN)
					take_command();
				else
					report_problem("tx", $sformatf("frame of %0d bytes is neither request nor command",
						frame_q.size()));
				frame_q.delete();
			end
			en_prev = tx_enable;
		end
	end

endmodule

`default_nettype wire

// ==== uart_byte_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_byte_rx (
	input logic clk,
	input logic reset,
	input logic line,
	output logic valid,
	output logic [7:0] data
);

	logic [1:0] sync;
	logic busy;
	logic [bus_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [3:0] bit_cnt; // 0 start, 1..8 data, 9 stop

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync <= 2'b11;
			busy <= 1'b0;
			valid <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			sync <= {sync[0], line};
			valid <= 1'b0;
			if (!busy) begin
				if (!sync[1]) begin
					busy <= 1'b1;
					clk_cnt <= bus_pkg::HALF_BIT; // land in mid start bit
					bit_cnt <= '0;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= bus_pkg::BIT_END;
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'd0 && sync[1]) begin
					busy <= 1'b0; // glitch, no real start bit
				end else if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					valid <= sync[1]; // bad stop bit drops the byte
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy && clk_cnt == '0 && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			data <= {sync[1], data[7:1]};
	end

endmodule

`default_nettype wire

// ==== uart_byte_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_byte_tx (
	input logic clk,
	input logic reset,
	input logic req,
	input logic [7:0] data,
	output logic ack,
	output logic line
);

	logic busy;
	logic [bus_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [3:0] bit_cnt; // 0..7 data, 8 stop, 9 done
	logic [7:0] shift;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			ack <= 1'b0;
			line <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (clk_cnt == bus_pkg::BIT_END) begin
				clk_cnt <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					ack <= 1'b1;
				end else if (bit_cnt == 4'd8) begin
					line <= 1'b1; // stop bit
				end else begin
					line <= shift[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end else if (ack) begin
			if (!req)
				ack <= 1'b0;
		end else if (req) begin
			busy <= 1'b1;
			line <= 1'b0; // start bit
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && !ack && req)
			shift <= data;
		else if (busy && clk_cnt == bus_pkg::BIT_END && bit_cnt < 4'd8)
			shift <= {1'b0, shift[7:1]}; // lsb first
	end

	a_data_stable: assert property (@(posedge clk) disable iff (reset)
		(req && !ack) ##1 (req && !ack) |-> $stable(data));

endmodule

`default_nettype wire
